// File: hdl/mx_pkg.sv
// Matrix-vector engine shared sizes
// Array geometry, accumulator width and Wishbone register map

`default_nettype none

package mx_pkg;

  // Operand geometry
  localparam int unsigned ELEM_W    = 8;                   // Signed element
  localparam int unsigned ARRAY_H   = 4;                   // Elements per depth slice
  localparam int unsigned ARRAY_W   = 4;                   // X rows and accumulators
  localparam int unsigned DEPTH_D   = 2;                   // Slices per row
  localparam int unsigned TOT_DEPTH = ARRAY_H * DEPTH_D;   // Row length in elements
  localparam int unsigned ROW_W     = TOT_DEPTH * ELEM_W;  // 64 bits
  localparam int unsigned STEP_W    = (DEPTH_D > 1) ? $clog2(DEPTH_D) : 1;

  localparam int unsigned ACC_W = 20;  // Holds 8 products of -128 x -128
  localparam int unsigned CNT_W = 4;   // Leftover rows and columns

  // Bus
  localparam int unsigned ADR_W = 6;
  localparam int unsigned DAT_W = 32;

  localparam logic [ADR_W-1:0] REG_CTRL   = 6'h00;
  localparam logic [ADR_W-1:0] REG_CFG    = 6'h04;
  localparam logic [ADR_W-1:0] REG_ROW_LO = 6'h08;
  localparam logic [ADR_W-1:0] REG_ROW_HI = 6'h0C;
  localparam logic [ADR_W-1:0] REG_Y_LO   = 6'h10;
  localparam logic [ADR_W-1:0] REG_Y_HI   = 6'h14;
  localparam logic [ADR_W-1:0] REG_STATUS = 6'h18;
  localparam logic [ADR_W-1:0] REG_RES0   = 6'h20;  // One word per row after this

  // STATUS bits
  localparam int unsigned ST_BUSY = 0;
  localparam int unsigned ST_DONE = 1;
  localparam int unsigned ST_FULL = 2;

endpackage

`default_nettype wire

// File: hdl/mx_wb_regs.sv
// Wishbone classic register slave
// Holds configuration, row assembly and Y vector, turns writes into engine pulses

`timescale 1ns/10ps
`default_nettype none

module mx_wb_regs (
  input  wire logic                                            clk_i,
  input  wire logic                                            rst_ni,
  input  wire logic                                            wb_cyc_i,
  input  wire logic                                            wb_stb_i,
  input  wire logic                                            wb_we_i,
  input  wire logic [mx_pkg::ADR_W-1:0]                        wb_adr_i,
  input  wire logic [mx_pkg::DAT_W-1:0]                        wb_dat_i,
  output logic      [mx_pkg::DAT_W-1:0]                        wb_dat_o,
  output logic                                                 wb_ack_o,
  input  wire logic                                            full_i,
  input  wire logic                                            busy_i,
  input  wire logic                                            done_i,
  input  wire logic [mx_pkg::ARRAY_W-1:0][mx_pkg::ACC_W-1:0]   result_i,
  output logic                                                 start_o,
  output logic                                                 clear_o,
  output logic                                                 load_o,
  output logic      [mx_pkg::ROW_W-1:0]                        row_o,
  output logic      [mx_pkg::CNT_W-1:0]                        rows_lftovr_o,
  output logic      [mx_pkg::CNT_W-1:0]                        cols_lftovr_o,
  output logic      [mx_pkg::TOT_DEPTH-1:0][mx_pkg::ELEM_W-1:0] y_vec_o
);

  localparam int unsigned HALF_Y = mx_pkg::TOT_DEPTH / 2;  // Elements per Y word

  logic                       ack_q;
  logic                       req;
  logic                       wr_ok;
  logic [mx_pkg::DAT_W-1:0]   row_lo_q;
  logic [mx_pkg::DAT_W-1:0]   rd_data;
  logic [mx_pkg::DAT_W-1:0]   rd_q;
  logic [mx_pkg::CNT_W-1:0]   rows_q, cols_q;
  logic                       done_q;
  logic [mx_pkg::TOT_DEPTH-1:0][mx_pkg::ELEM_W-1:0] y_q;

  // New request only when not already acknowledging, so ack never repeats
  assign req   = wb_cyc_i & wb_stb_i & ~ack_q;
  // Writes take effect in the ack cycle while the master still holds its signals
  assign wr_ok = ack_q & wb_cyc_i & wb_stb_i & wb_we_i & ~busy_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  assign clear_o = wr_ok & (wb_adr_i == mx_pkg::REG_CFG);
  assign load_o  = wr_ok & (wb_adr_i == mx_pkg::REG_ROW_HI);
  assign start_o = wr_ok & (wb_adr_i == mx_pkg::REG_CTRL) & wb_dat_i[0];
  assign row_o   = {wb_dat_i, row_lo_q};  // Element 0 in the low byte

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rows_q <= '0;
      cols_q <= '0;
      done_q <= 1'b0;
    end else begin
      if (clear_o) begin
        rows_q <= mx_pkg::CNT_W'(wb_dat_i[2:0]);
        cols_q <= wb_dat_i[6:3];
      end
      if (clear_o || start_o) begin
        done_q <= 1'b0;
      end else if (done_i) begin
        done_q <= 1'b1;  // Sticky until next CFG or start
      end
    end
  end

  // Row low word and Y vector
  always_ff @(posedge clk_i) begin
    if (wr_ok && wb_adr_i == mx_pkg::REG_ROW_LO) begin
      row_lo_q <= wb_dat_i;
    end
    if (wr_ok && wb_adr_i == mx_pkg::REG_Y_LO) begin
      y_q[HALF_Y-1:0] <= wb_dat_i;
    end
    if (wr_ok && wb_adr_i == mx_pkg::REG_Y_HI) begin
      y_q[mx_pkg::TOT_DEPTH-1:HALF_Y] <= wb_dat_i;
    end
  end

  always_comb begin
    rd_data = '0;  // Unmapped reads return zero
    case (wb_adr_i)
      mx_pkg::REG_CFG: begin
        rd_data[2:0] = rows_q[2:0];
        rd_data[6:3] = cols_q;
      end
      mx_pkg::REG_Y_LO:   rd_data = y_q[HALF_Y-1:0];
      mx_pkg::REG_Y_HI:   rd_data = y_q[mx_pkg::TOT_DEPTH-1:HALF_Y];
      mx_pkg::REG_STATUS: begin
        rd_data[mx_pkg::ST_BUSY] = busy_i;
        rd_data[mx_pkg::ST_DONE] = done_q;
        rd_data[mx_pkg::ST_FULL] = full_i;
      end
      default: rd_data = '0;
    endcase
    for (int n = 0; n < mx_pkg::ARRAY_W; n++) begin
      if (wb_adr_i == mx_pkg::ADR_W'(mx_pkg::REG_RES0 + 4 * n)) begin
        // Sign extension of the accumulator
        rd_data = {{(mx_pkg::DAT_W - mx_pkg::ACC_W){result_i[n][mx_pkg::ACC_W-1]}},
                   result_i[n]};
      end
    end
  end

  // Read data captured with the request, presented with ack
  always_ff @(posedge clk_i) begin
    if (req) begin
      rd_q <= rd_data;
    end
  end

  assign wb_dat_o      = rd_q;
  assign wb_ack_o      = ack_q;
  assign rows_lftovr_o = rows_q;
  assign cols_lftovr_o = cols_q;
  assign y_vec_o       = y_q;

endmodule

`default_nettype wire

// File: hdl/mx_x_buffer.sv
// X operand staging buffer
// Loads full rows with column padding, shifts depth slices out, tracks full and empty

`timescale 1ns/10ps
`default_nettype none

module mx_x_buffer (
  input  wire logic                                    clk_i,
  input  wire logic                                    rst_ni,
  input  wire logic                                    clear_i,
  input  wire logic                                    load_i,
  input  wire logic                                    d_shift_i,
  input  wire logic [mx_pkg::CNT_W-1:0]                rows_lftovr_i,
  input  wire logic [mx_pkg::CNT_W-1:0]                cols_lftovr_i,
  input  wire logic [mx_pkg::ROW_W-1:0]                x_buffer_i,
  output logic [mx_pkg::ARRAY_W-1:0][mx_pkg::ARRAY_H-1:0][mx_pkg::ELEM_W-1:0] x_buffer_o,
  output logic                                         full_o,
  output logic                                         empty_o
);

  localparam int unsigned H = mx_pkg::ARRAY_H;
  localparam int unsigned W = mx_pkg::ARRAY_W;
  localparam int unsigned D = mx_pkg::DEPTH_D;
  localparam int unsigned E = mx_pkg::ELEM_W;

  logic [D-1:0][W-1:0][H-1:0][E-1:0] pad_q;
  logic [W-1:0][H-1:0][E-1:0]        out_q;
  logic [mx_pkg::CNT_W-1:0]          row_idx_q;
  logic [mx_pkg::CNT_W-1:0]          row_limit;
  logic [mx_pkg::CNT_W-1:0]          depth;
  logic [mx_pkg::CNT_W-1:0]          slots;
  logic [mx_pkg::CNT_W-1:0]          slot_q;
  logic [mx_pkg::CNT_W-1:0]          shift_cnt_q;
  logic                              load_ok;

  // Zero leftover means full size, oversize values are clamped
  assign depth = (cols_lftovr_i == '0 || cols_lftovr_i > mx_pkg::CNT_W'(mx_pkg::TOT_DEPTH)) ?
                 mx_pkg::CNT_W'(mx_pkg::TOT_DEPTH) : cols_lftovr_i;
  assign row_limit = (rows_lftovr_i == '0 || rows_lftovr_i > mx_pkg::CNT_W'(W)) ?
                     mx_pkg::CNT_W'(W) : rows_lftovr_i;
  assign slots = (depth + mx_pkg::CNT_W'(H - 1)) / mx_pkg::CNT_W'(H);  // ceil(depth/H)

  assign full_o  = (row_idx_q >= row_limit);
  assign load_ok = load_i & ~full_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pad_q <= '0;
      out_q <= '0;
    end else if (clear_i) begin
      pad_q <= '0;
      out_q <= '0;
    end else if (load_ok) begin
      for (int d = 0; d < D; d++) begin
        for (int h = 0; h < H; h++) begin
          // Columns at or past the effective depth are padded
          pad_q[d][row_idx_q][h] <= ((H * d + h) < int'(depth)) ?
                                    x_buffer_i[(H * d + h) * E +: E] : '0;
        end
      end
    end else if (d_shift_i) begin
      out_q <= pad_q[0];
      for (int d = 0; d < D - 1; d++) begin
        pad_q[d] <= pad_q[d + 1];
      end
      pad_q[D-1] <= '0;  // Top slice fills with zero
    end
  end

  // Rows loaded since the last clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      row_idx_q <= '0;
    end else if (clear_i) begin
      row_idx_q <= '0;
    end else if (load_ok) begin
      row_idx_q <= row_idx_q + 1'b1;
    end
  end

  // Slot count follows the config between shift sequences
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_q <= mx_pkg::CNT_W'(D);
    end else if (shift_cnt_q == '0) begin
      slot_q <= slots;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shift_cnt_q <= '0;
    end else if (clear_i || empty_o) begin
      shift_cnt_q <= '0;  // Rewind once drained
    end else if (d_shift_i) begin
      shift_cnt_q <= shift_cnt_q + 1'b1;
    end
  end

  assign empty_o    = (shift_cnt_q == slot_q);
  assign x_buffer_o = out_q;

endmodule

`default_nettype wire

// File: hdl/mx_sequencer.sv
// Run controller
// Issues depth shifts until the buffer drains, then accumulate enables and done

`timescale 1ns/10ps
`default_nettype none

module mx_sequencer (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire logic                       start_i,
  input  wire logic                       empty_i,
  output logic                            d_shift_o,
  output logic                            acc_en_o,
  output logic                            acc_clr_o,
  output logic [mx_pkg::STEP_W-1:0]       step_o,
  output logic                            busy_o,
  output logic                            done_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_SHIFT,
    S_DRAIN
  } state_e;

  state_e                      state_q;
  logic [mx_pkg::STEP_W-1:0]   step_cnt_q;
  logic [mx_pkg::STEP_W-1:0]   step_q;
  logic                        acc_en_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE:  if (start_i) state_q <= S_SHIFT;
        S_SHIFT: if (empty_i) state_q <= S_DRAIN;
        S_DRAIN: state_q <= S_IDLE;  // Last accumulate has landed
        default: state_q <= S_IDLE;
      endcase
    end
  end

  assign acc_clr_o = (state_q == S_IDLE) & start_i;
  assign d_shift_o = (state_q == S_SHIFT) & ~empty_i;

  // Output slice lags the shift by one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      step_cnt_q <= '0;
      step_q     <= '0;
      acc_en_q   <= 1'b0;
    end else begin
      acc_en_q <= d_shift_o;
      if (d_shift_o) begin
        step_q <= step_cnt_q;
      end
      if (acc_clr_o) begin
        step_cnt_q <= '0;
      end else if (d_shift_o) begin
        step_cnt_q <= step_cnt_q + 1'b1;
      end
    end
  end

  assign acc_en_o = acc_en_q;
  assign step_o   = step_q;
  assign busy_o   = (state_q != S_IDLE);
  assign done_o   = (state_q == S_DRAIN);

endmodule

`default_nettype wire

// File: hdl/mx_dot_array.sv
// Dot product array
// One row of signed multipliers per X row, each summed into its own accumulator

`timescale 1ns/10ps
`default_nettype none

module mx_dot_array (
  input  wire logic                                       clk_i,
  input  wire logic                                       rst_ni,
  input  wire logic                                       acc_clr_i,
  input  wire logic                                       acc_en_i,
  input  wire logic [mx_pkg::STEP_W-1:0]                  step_i,
  input  wire logic [mx_pkg::ARRAY_W-1:0][mx_pkg::ARRAY_H-1:0][mx_pkg::ELEM_W-1:0] x_slice_i,
  input  wire logic [mx_pkg::TOT_DEPTH-1:0][mx_pkg::ELEM_W-1:0] y_vec_i,
  output logic      [mx_pkg::ARRAY_W-1:0][mx_pkg::ACC_W-1:0]   result_o
);

  localparam int unsigned H = mx_pkg::ARRAY_H;
  localparam int unsigned W = mx_pkg::ARRAY_W;

  logic signed [2*mx_pkg::ELEM_W-1:0] prod [W][H];
  logic signed [mx_pkg::ACC_W-1:0]    row_sum [W];
  logic [mx_pkg::ELEM_W-1:0]          y_sel [H];
  logic [W-1:0][mx_pkg::ACC_W-1:0]    acc_q;

  always_comb begin
    for (int h = 0; h < H; h++) begin
      y_sel[h] = y_vec_i[int'(step_i) * H + h];  // Y slice matching this step
    end
    for (int w = 0; w < W; w++) begin
      row_sum[w] = '0;
      for (int h = 0; h < H; h++) begin
        prod[w][h] = $signed(x_slice_i[w][h]) * $signed(y_sel[h]);
        row_sum[w] = row_sum[w] + mx_pkg::ACC_W'(prod[w][h]);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (acc_clr_i) begin
      acc_q <= '0;
    end else if (acc_en_i) begin
      for (int w = 0; w < W; w++) begin
        acc_q[w] <= acc_q[w] + row_sum[w];
      end
    end
  end

  assign result_o = acc_q;

endmodule

`default_nettype wire

// File: hdl/mx_top.sv
// Matrix-vector engine top
// Wishbone registers, X staging buffer, run sequencer and dot array

`timescale 1ns/10ps
`default_nettype none

module mx_top (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire logic                       wb_cyc_i,
  input  wire logic                       wb_stb_i,
  input  wire logic                       wb_we_i,
  input  wire logic [mx_pkg::ADR_W-1:0]   wb_adr_i,
  input  wire logic [mx_pkg::DAT_W-1:0]   wb_dat_i,
  output logic      [mx_pkg::DAT_W-1:0]   wb_dat_o,
  output logic                            wb_ack_o
);

  logic                               start, clear, load;
  logic                               full, empty, busy, done;
  logic                               d_shift, acc_en, seq_acc_clr, acc_clr;
  logic [mx_pkg::STEP_W-1:0]          step;
  logic [mx_pkg::ROW_W-1:0]           row;
  logic [mx_pkg::CNT_W-1:0]           rows_lftovr, cols_lftovr;
  logic [mx_pkg::TOT_DEPTH-1:0][mx_pkg::ELEM_W-1:0]                    y_vec;
  logic [mx_pkg::ARRAY_W-1:0][mx_pkg::ACC_W-1:0]                       result;
  logic [mx_pkg::ARRAY_W-1:0][mx_pkg::ARRAY_H-1:0][mx_pkg::ELEM_W-1:0] x_slice;

  // Accumulators zero on run start and on every CFG write
  assign acc_clr = seq_acc_clr | clear;

  mx_wb_regs i_regs (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .full_i        (full),
    .busy_i        (busy),
    .done_i        (done),
    .result_i      (result),
    .start_o       (start),
    .clear_o       (clear),
    .load_o        (load),
    .row_o         (row),
    .rows_lftovr_o (rows_lftovr),
    .cols_lftovr_o (cols_lftovr),
    .y_vec_o       (y_vec)
  );

  mx_x_buffer i_x_buffer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear),
    .load_i        (load),
    .d_shift_i     (d_shift),
    .rows_lftovr_i (rows_lftovr),
    .cols_lftovr_i (cols_lftovr),
    .x_buffer_i    (row),
    .x_buffer_o    (x_slice),
    .full_o        (full),
    .empty_o       (empty)
  );

  mx_sequencer i_sequencer (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .start_i   (start),
    .empty_i   (empty),
    .d_shift_o (d_shift),
    .acc_en_o  (acc_en),
    .acc_clr_o (seq_acc_clr),
    .step_o    (step),
    .busy_o    (busy),
    .done_o    (done)
  );

  mx_dot_array i_dot_array (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .acc_clr_i (acc_clr),
    .acc_en_i  (acc_en),
    .step_i    (step),
    .x_slice_i (x_slice),
    .y_vec_i   (y_vec),
    .result_o  (result)
  );

endmodule

`default_nettype wire

// File: bench/mx_clk_gen.sv
// Testbench clock and reset
// 8 ns clock, active-low reset held for the first three cycles

`timescale 1ns/10ps
`default_nettype none

module mx_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
  end

  always #4 clk_o = ~clk_o;  // 8 ns period

  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

// File: bench/mx_checker.sv
// Bus checker for the matrix-vector engine
// Mirrors accepted writes in a reference model, compares STATUS, Y and RESULT reads

`timescale 1ns/10ps
`default_nettype none

module mx_checker (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     wb_cyc_i,
  input  wire logic                     wb_stb_i,
  input  wire logic                     wb_we_i,
  input  wire logic [mx_pkg::ADR_W-1:0] wb_adr_i,
  input  wire logic [mx_pkg::DAT_W-1:0] wb_dat_i,
  input  wire logic [mx_pkg::DAT_W-1:0] wb_rdat_i,
  input  wire logic                     wb_ack_i,
  output int                            err_cnt_o,
  output int                            chk_cnt_o
);

  localparam int E = mx_pkg::ELEM_W;

  logic [mx_pkg::ROW_W-1:0] x_m [mx_pkg::ARRAY_W];  // Rows as loaded, unpadded
  logic [mx_pkg::ROW_W-1:0] y_m;
  logic [mx_pkg::DAT_W-1:0] lo_m;
  logic [mx_pkg::DAT_W-1:0] exp_rd;
  int                       z_m [mx_pkg::ARRAY_W];
  int                       lim_m;
  int                       depth_m;
  int                       loaded_m;
  int                       busy_cnt;  // Cycles of the run still to come
  logic                     done_m;
  logic                     busy_m;
  logic                     cmp_en;
  string                    rd_name;

  initial begin
    err_cnt_o = 0;
    chk_cnt_o = 0;
  end

  // Expected Z[w], columns at or beyond the leftover count add nothing
  function automatic int dot_ref(input int w);
    int sum;
    sum = 0;
    for (int k = 0; k < depth_m; k++) begin
      sum += int'($signed(x_m[w][E*k +: E])) * int'($signed(y_m[E*k +: E]));
    end
    return sum;
  endfunction

  task automatic clear_model();
    for (int w = 0; w < mx_pkg::ARRAY_W; w++) begin
      x_m[w] = '0;
      z_m[w] = 0;
    end
    loaded_m = 0;
    done_m   = 1'b0;
  endtask

  // Expected read data from the state seen with the request
  task automatic capture_expected();
    cmp_en = 1'b0;
    if (!wb_we_i && wb_adr_i == mx_pkg::REG_STATUS) begin
      exp_rd = '0;
      exp_rd[mx_pkg::ST_BUSY] = busy_m;
      exp_rd[mx_pkg::ST_DONE] = done_m;
      exp_rd[mx_pkg::ST_FULL] = (loaded_m >= lim_m);
      rd_name = "STATUS";
      cmp_en  = 1'b1;
    end
    if (!wb_we_i && wb_adr_i == mx_pkg::REG_Y_LO) begin
      exp_rd  = y_m[mx_pkg::DAT_W-1:0];
      rd_name = "Y_LO";
      cmp_en  = 1'b1;
    end
    for (int n = 0; n < mx_pkg::ARRAY_W; n++) begin
      if (!wb_we_i && wb_adr_i == mx_pkg::ADR_W'(mx_pkg::REG_RES0 + 4 * n)) begin
        exp_rd  = z_m[n];
        rd_name = $sformatf("RESULT%0d", n);
        cmp_en  = 1'b1;
      end
    end
  endtask

  task automatic compare_read();
    chk_cnt_o++;
    if (wb_rdat_i !== exp_rd) begin
      err_cnt_o++;
      $display("MISMATCH at %0t: %s read %0d (0x%08h), expected %0d (0x%08h)", $time,
               rd_name, $signed(wb_rdat_i), wb_rdat_i, $signed(exp_rd), exp_rd);
    end
  endtask

  task automatic apply_write();
    case (wb_adr_i)
      mx_pkg::REG_CFG: begin
        lim_m   = int'(wb_dat_i[2:0]);
        depth_m = int'(wb_dat_i[6:3]);
        if (lim_m == 0 || lim_m > int'(mx_pkg::ARRAY_W)) lim_m = mx_pkg::ARRAY_W;
        if (depth_m == 0 || depth_m > int'(mx_pkg::TOT_DEPTH)) depth_m = mx_pkg::TOT_DEPTH;
        clear_model();  // Buffer and accumulators cleared
      end
      mx_pkg::REG_ROW_LO: lo_m = wb_dat_i;
      mx_pkg::REG_ROW_HI: begin
        if (loaded_m < lim_m) begin  // Dropped once full
          x_m[loaded_m] = {wb_dat_i, lo_m};
          loaded_m++;
        end
      end
      mx_pkg::REG_Y_LO: y_m[mx_pkg::DAT_W-1:0] = wb_dat_i;
      mx_pkg::REG_Y_HI: y_m[mx_pkg::ROW_W-1:mx_pkg::DAT_W] = wb_dat_i;
      mx_pkg::REG_CTRL: begin
        if (wb_dat_i[0]) begin
          for (int w = 0; w < mx_pkg::ARRAY_W; w++) begin
            z_m[w] = dot_ref(w);
            x_m[w] = '0;  // Shifted out by the run
          end
          done_m   = 1'b0;
          busy_cnt = (depth_m + mx_pkg::ARRAY_H - 1) / mx_pkg::ARRAY_H + 2;
        end
      end
      default: ;
    endcase
  endtask

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lim_m    = mx_pkg::ARRAY_W;
      depth_m  = mx_pkg::TOT_DEPTH;
      busy_cnt = 0;
      cmp_en   = 1'b0;
      y_m      = '0;
      lo_m     = '0;
      clear_model();
    end else begin
      busy_m = (busy_cnt != 0);  // Engine state in the cycle just ended
      if (wb_cyc_i && wb_stb_i && !wb_ack_i) begin
        capture_expected();
      end
      if (wb_cyc_i && wb_stb_i && wb_ack_i && !wb_we_i && cmp_en) begin
        compare_read();
      end
      if (busy_cnt == 1) done_m = 1'b1;  // Drain cycle
      if (busy_cnt != 0) busy_cnt--;
      if (wb_cyc_i && wb_stb_i && wb_ack_i && wb_we_i && !busy_m) begin
        apply_write();
      end
    end
  end

endmodule

`default_nettype wire

// File: bench/mx_bus_sva.sv
// Wishbone slave protocol assertions
// Bound into the engine top level

`timescale 1ns/10ps
`default_nettype none

module mx_bus_sva (
  input wire logic                     clk_i,
  input wire logic                     rst_ni,
  input wire logic                     wb_cyc_i,
  input wire logic                     wb_stb_i,
  input wire logic                     wb_we_i,
  input wire logic [mx_pkg::DAT_W-1:0] wb_dat_o,
  input wire logic                     wb_ack_o
);

  // Ack answers a request seen one cycle earlier
  ack_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
    else $error("Wishbone ack without a preceding request");

  ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_o |=> !wb_ack_o)
    else $error("Wishbone ack held for two consecutive cycles");

  read_data_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_ack_o && !wb_we_i) |-> !$isunknown(wb_dat_o))
    else $error("Wishbone read data has unknown bits");

endmodule

bind mx_top mx_bus_sva i_bus_sva (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .wb_cyc_i (wb_cyc_i),
  .wb_stb_i (wb_stb_i),
  .wb_we_i  (wb_we_i),
  .wb_dat_o (wb_dat_o),
  .wb_ack_o (wb_ack_o)
);

`default_nettype wire

// File: bench/mx_tb.sv
// Matrix-vector engine testbench
// Wishbone traffic through six tests, read data compared by the checker

`timescale 1ns/10ps
`default_nettype none

module mx_tb;

  localparam int TIMEOUT_CYCLES = 1500;  // 6 tests x 60 transactions x 4 cycles

  logic                     clk;
  logic                     rst_n;
  logic                     wb_cyc;
  logic                     wb_stb;
  logic                     wb_we;
  logic [mx_pkg::ADR_W-1:0] wb_adr;
  logic [mx_pkg::DAT_W-1:0] wb_dat_w;
  logic [mx_pkg::DAT_W-1:0] wb_dat_r;
  logic                     wb_ack;
  logic [mx_pkg::ROW_W-1:0] rows_t [mx_pkg::ARRAY_W];
  logic [mx_pkg::ROW_W-1:0] y_t;
  logic [mx_pkg::DAT_W-1:0] rd;
  int                       err_cnt;
  int                       chk_cnt;
  int                       cycles;
  int                       test_num;
  int                       test_errs;

  mx_clk_gen i_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  mx_top i_dut (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack)
  );

  mx_checker i_checker (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .wb_cyc_i  (wb_cyc),
    .wb_stb_i  (wb_stb),
    .wb_we_i   (wb_we),
    .wb_adr_i  (wb_adr),
    .wb_dat_i  (wb_dat_w),
    .wb_rdat_i (wb_dat_r),
    .wb_ack_i  (wb_ack),
    .err_cnt_o (err_cnt),
    .chk_cnt_o (chk_cnt)
  );

  // Signals held through the ack cycle, ack sampled on the falling edge
  task automatic bus_access(input logic we, input logic [mx_pkg::ADR_W-1:0] adr,
                            input logic [mx_pkg::DAT_W-1:0] wdat,
                            output logic [mx_pkg::DAT_W-1:0] rdat);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdat;
    do @(negedge clk); while (wb_ack !== 1'b1);
    rdat = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic bus_write(input logic [mx_pkg::ADR_W-1:0] adr,
                           input logic [mx_pkg::DAT_W-1:0] dat);
    logic [mx_pkg::DAT_W-1:0] unused;
    bus_access(1'b1, adr, dat, unused);
  endtask

  task automatic bus_read(input logic [mx_pkg::ADR_W-1:0] adr,
                          output logic [mx_pkg::DAT_W-1:0] dat);
    bus_access(1'b0, adr, '0, dat);
  endtask

  task automatic wait_done();
    logic [mx_pkg::DAT_W-1:0] st;
    st = '0;
    while (st[mx_pkg::ST_DONE] !== 1'b1) begin
      bus_read(mx_pkg::REG_STATUS, st);
    end
  endtask

  task automatic read_results();
    for (int n = 0; n < mx_pkg::ARRAY_W; n++) begin
      bus_read(mx_pkg::ADR_W'(mx_pkg::REG_RES0 + 4 * n), rd);
    end
  endtask

  task automatic fill_random();
    for (int i = 0; i < mx_pkg::ARRAY_W; i++) begin
      rows_t[i] = {$urandom, $urandom};
    end
    y_t = {$urandom, $urandom};
  endtask

  // CFG, row loads, Y, start, then results once done
  task automatic run_case(input logic [mx_pkg::DAT_W-1:0] cfg, input int nrows,
                          input bit poke_busy);
    bus_write(mx_pkg::REG_CFG, cfg);
    for (int i = 0; i < nrows; i++) begin
      bus_write(mx_pkg::REG_ROW_LO, rows_t[i][31:0]);
      bus_write(mx_pkg::REG_ROW_HI, rows_t[i][63:32]);
    end
    bus_read(mx_pkg::REG_STATUS, rd);  // Full flag
    bus_write(mx_pkg::REG_Y_LO, y_t[31:0]);
    bus_write(mx_pkg::REG_Y_HI, y_t[63:32]);
    bus_write(mx_pkg::REG_CTRL, 32'h1);
    if (poke_busy) begin
      bus_write(mx_pkg::REG_Y_LO, ~y_t[31:0]);  // Lands while the run is active
    end
    wait_done();
    if (poke_busy) begin
      bus_read(mx_pkg::REG_Y_LO, rd);  // Still the value from before start
    end
    read_results();
  endtask

  task automatic report_test(input string name);
    @(negedge clk);  // Checker counts settle on the rising edge
    test_num++;
    $display("Test %0d %s: %s, %0d errors", test_num, name,
             (err_cnt == test_errs) ? "PASS" : "FAIL", err_cnt - test_errs);
    test_errs = err_cnt;
  endtask

  initial begin
    void'($urandom(76521));
    wb_cyc   <= 1'b0;
    wb_stb   <= 1'b0;
    wb_we    <= 1'b0;
    wb_adr   <= '0;
    wb_dat_w <= '0;
    test_num  = 0;
    test_errs = 0;
    wait (rst_n === 1'b1);
    bus_read(mx_pkg::REG_STATUS, rd);
    read_results();
    report_test("reset state");
    fill_random();
    run_case(32'h0, 4, 1'b0);
    report_test("full size");
    fill_random();
    run_case(32'h2, 3, 1'b0);  // Third row is dropped
    report_test("leftover rows");
    fill_random();
    run_case(32'(3 << 3), 4, 1'b0);
    fill_random();
    run_case(32'(5 << 3), 4, 1'b0);
    report_test("leftover columns");
    fill_random();
    run_case(32'h0, 4, 1'b1);
    report_test("writes while busy");
    for (int i = 0; i < mx_pkg::ARRAY_W; i++) begin
      rows_t[i] = {8{8'h80}};
    end
    y_t = {8{8'h80}};  // Largest positive sums
    run_case(32'h0, 4, 1'b0);
    y_t = {8{8'h7f}};  // Largest negative sums
    run_case(32'h0, 4, 1'b0);
    report_test("extreme values");
    $display("Tests: %0d, checks: %0d, errors: %0d", test_num, chk_cnt, err_cnt);
    if (err_cnt == 0 && chk_cnt > 0) begin
      $display("Everything OK");
    end else begin
      if (chk_cnt == 0) $display("No read data was checked");
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the tests did not finish", cycles);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
hdl/mx_pkg.sv
hdl/mx_wb_regs.sv
hdl/mx_x_buffer.sv
hdl/mx_sequencer.sv
hdl/mx_dot_array.sv
hdl/mx_top.sv
bench/mx_clk_gen.sv
bench/mx_checker.sv
bench/mx_bus_sva.sv
bench/mx_tb.sv
